// ==== Bender.yml ====
package:
  name: dma_controller

sources:
  - files:
      - common/dma_pkg.sv
      - logic/dma_slave_regs.sv
      - logic/disk_line_fetch.sv
      - logic/dma_bus_master.sv
      - logic/dma_controller.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_dma_controller.sv

// ==== common/dma_pkg.sv ====
// DMA shared definitions
`default_nettype none

package dma_pkg;

   // bus field widths
   localparam int unsigned ADDR_W = 16;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned SIZE_W = 12;

   // one line is four words of four bytes
   localparam int unsigned LINE_BYTES = 16;
   localparam int unsigned LINE_WORDS = 4;
   localparam int unsigned WORD_IDX_W = $clog2(LINE_WORDS);

   // register window 0x7000 to 0x701f
   localparam logic [11:0] DMA_PAGE = 12'h700;

   // register select, bits 4:2 of the bus address
   localparam logic [2:0] SEL_DISK_ADDR = 3'd1;
   localparam logic [2:0] SEL_MEM_ADDR  = 3'd2;
   localparam logic [2:0] SEL_SIZE      = 3'd3;
   localparam logic [2:0] SEL_ENABLE    = 3'd4;

   // one-hot bit positions of the bus master FSM
   localparam int unsigned MST_IDLE = 0;
   localparam int unsigned MST_REQ  = 1;
   localparam int unsigned MST_ADDR = 2;
   localparam int unsigned MST_DATA = 3;
   localparam int unsigned MST_REL  = 4;
   localparam int unsigned MST_W    = 5;

   // one bus address, seen whole or split into fields
   // the page field is 11 bits here because bit 4 is the top of reg_sel
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      struct packed {
         logic [10:0] page_hi;
         logic [2:0]  reg_sel;
         logic [1:0]  byte_off;
      } f;
   } reg_addr_u;

endpackage

`default_nettype wire

// ==== dma_controller.f ====
common/dma_pkg.sv
logic/dma_slave_regs.sv
logic/disk_line_fetch.sv
logic/dma_bus_master.sv
logic/dma_controller.sv
testbench/tb_clock_gen.sv
testbench/tb_dma_controller.sv

// ==== logic/disk_line_fetch.sv ====
// Disk line fetcher
`default_nettype none

module disk_line_fetch (
   input  wire                                              DONE,
   input  wire                                              rst_n,
   input  wire                                              enable,
   input  wire  [dma_pkg::DATA_W-1:0]                       disk_addr,
   input  wire                                              line_done,
   output logic                                             disk_rd,
   output logic [dma_pkg::DATA_W-1:0]                       disk_rd_addr,
   input  wire  [dma_pkg::DATA_W-1:0]                       disk_data,
   input  wire                                              disk_valid,
   output logic                                             line_ready,
   output logic [dma_pkg::LINE_WORDS*dma_pkg::DATA_W-1:0]   line_data
);

   logic [dma_pkg::WORD_IDX_W-1:0] word_cnt;
   logic                           rd_pending;
   logic                           issue;

   // one read at a time, none while a full line waits for the master
   assign issue = enable && !line_ready && !rd_pending;

   always_ff @(posedge DONE or negedge rst_n)
   begin
      if (!rst_n)
      begin
         disk_rd    <= 1'b0;
         rd_pending <= 1'b0;
         word_cnt   <= '0;
         line_ready <= 1'b0;
      end
      else
      begin
         disk_rd <= issue;

         if (issue)
            rd_pending <= 1'b1;
         else if (disk_valid)
            rd_pending <= 1'b0;

         if (disk_valid)
         begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == dma_pkg::WORD_IDX_W'(dma_pkg::LINE_WORDS - 1))
               line_ready <= 1'b1;
         end

         // buffer is free again once the line is on the bus
         if (line_done)
            line_ready <= 1'b0;
      end
   end

   // word address and buffer slot both follow the counter
   always_ff @(posedge DONE)
   begin
      if (issue)
         disk_rd_addr <= disk_addr + dma_pkg::DATA_W'({word_cnt, 2'b00});
      if (disk_valid)
         line_data[word_cnt*dma_pkg::DATA_W +: dma_pkg::DATA_W] <= disk_data;
   end

   a_no_read_when_full : assert property (
      @(posedge DONE) disable iff (!rst_n)
      disk_rd |-> !line_ready
   ) else $error("disk_rd while line buffer is full");

   // disk must only answer a read we issued
   a_valid_has_read : assert property (
      @(posedge DONE) disable iff (!rst_n)
      disk_valid |-> rd_pending
   ) else $error("disk_valid with no read outstanding");

endmodule

`default_nettype wire

// ==== logic/dma_bus_master.sv ====
// DMA bus master
`default_nettype none

module dma_bus_master (
   input  wire                                            DONE,
   input  wire                                            rst_n,
   input  wire                                            enable,
   input  wire                                            line_ready,
   input  wire  [dma_pkg::LINE_WORDS*dma_pkg::DATA_W-1:0] line_data,
   input  wire  [dma_pkg::DATA_W-1:0]                     mem_addr,
   output logic                                           br,
   input  wire                                            bg,
   input  wire                                            ack_in,
   output logic [dma_pkg::ADDR_W-1:0]                     a_out,
   output logic [dma_pkg::SIZE_W-1:0]                     size_out,
   output logic                                           rw_out,
   output logic                                           ctrl_oe,
   output logic [dma_pkg::DATA_W-1:0]                     d_out,
   output logic                                           d_oe,
   output logic                                           line_done
);

   logic [dma_pkg::MST_W-1:0]      state;
   logic [dma_pkg::MST_W-1:0]      state_nxt;
   logic [dma_pkg::WORD_IDX_W-1:0] beat;
   logic                           last_beat;

   assign last_beat = (beat == dma_pkg::WORD_IDX_W'(dma_pkg::LINE_WORDS - 1));

   always_comb
   begin
      state_nxt = '0;
      case (1'b1)
         state[dma_pkg::MST_IDLE]:
         begin
            if (enable && line_ready)
               state_nxt[dma_pkg::MST_REQ] = 1'b1;
            else
               state_nxt[dma_pkg::MST_IDLE] = 1'b1;
         end
         state[dma_pkg::MST_REQ]:
         begin
            // hold the request until the arbiter grants
            if (bg)
               state_nxt[dma_pkg::MST_ADDR] = 1'b1;
            else
               state_nxt[dma_pkg::MST_REQ] = 1'b1;
         end
         state[dma_pkg::MST_ADDR]:
         begin
            if (ack_in)
               state_nxt[dma_pkg::MST_DATA] = 1'b1;
            else
               state_nxt[dma_pkg::MST_ADDR] = 1'b1;
         end
         state[dma_pkg::MST_DATA]:
         begin
            if (last_beat)
               state_nxt[dma_pkg::MST_REL] = 1'b1;
            else
               state_nxt[dma_pkg::MST_DATA] = 1'b1;
         end
         default:
            state_nxt[dma_pkg::MST_IDLE] = 1'b1;
      endcase
   end

   always_ff @(posedge DONE or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state                    <= '0;
         state[dma_pkg::MST_IDLE] <= 1'b1;
         beat                     <= '0;
      end
      else
      begin
         state <= state_nxt;
         // beat wraps back to zero after the last word
         if (state[dma_pkg::MST_DATA])
            beat <= beat + 1'b1;
         else
            beat <= '0;
      end
   end

   assign br = state[dma_pkg::MST_REQ] | state[dma_pkg::MST_ADDR] | state[dma_pkg::MST_DATA];

   // address phase, always a 16 byte write
   assign ctrl_oe  = state[dma_pkg::MST_ADDR];
   assign rw_out   = state[dma_pkg::MST_ADDR];
   assign a_out    = mem_addr[dma_pkg::ADDR_W-1:0];
   assign size_out = dma_pkg::SIZE_W'(dma_pkg::LINE_BYTES);

   // data beats, lowest word first
   assign d_oe  = state[dma_pkg::MST_DATA];
   assign d_out = line_data[beat*dma_pkg::DATA_W +: dma_pkg::DATA_W];

   assign line_done = state[dma_pkg::MST_REL];

   a_br_held : assert property (
      @(posedge DONE) disable iff (!rst_n)
      br |=> (br || line_done)
   ) else $error("br dropped before line_done");

   a_one_driver : assert property (
      @(posedge DONE) disable iff (!rst_n)
      !(d_oe && ctrl_oe)
   ) else $error("data and control enables both high");

endmodule

`default_nettype wire

// ==== logic/dma_controller.sv ====
// DMA controller top level
`default_nettype none

module dma_controller (
   input  wire                        DONE,
   input  wire                        rst_n,
   input  wire  [dma_pkg::DATA_W-1:0] d_in,
   input  wire  [dma_pkg::ADDR_W-1:0] a_in,
   input  wire                        rw_in,
   input  wire                        dest_in,
   output wire  [dma_pkg::DATA_W-1:0] d_out,
   output wire  [dma_pkg::ADDR_W-1:0] a_out,
   output wire  [dma_pkg::SIZE_W-1:0] size_out,
   output wire                        rw_out,
   output wire                        d_oe,
   output wire                        ctrl_oe,
   output wire                        br,
   input  wire                        bg,
   output wire                        ack_out,
   input  wire                        ack_in,
   output wire                        dest_intr,
   output wire  [dma_pkg::DATA_W-1:0] disk_addr,
   output wire                        disk_rd,
   input  wire  [dma_pkg::DATA_W-1:0] disk_data,
   input  wire                        disk_valid
);

   wire                                            enable;
   wire [dma_pkg::DATA_W-1:0]                      line_disk_addr;
   wire [dma_pkg::DATA_W-1:0]                      mem_addr;
   wire                                            line_ready;
   wire [dma_pkg::LINE_WORDS*dma_pkg::DATA_W-1:0]  line_data;
   wire                                            line_done;

   dma_slave_regs u_regs (
      .DONE      (DONE),
      .rst_n     (rst_n),
      .d_in      (d_in),
      .a_in      (a_in),
      .rw_in     (rw_in),
      .dest_in   (dest_in),
      .line_done (line_done),
      .ack_out   (ack_out),
      .enable    (enable),
      .disk_addr (line_disk_addr),
      .mem_addr  (mem_addr),
      .remaining (),
      .last_line (),
      .dest_intr (dest_intr)
   );

   disk_line_fetch u_fetch (
      .DONE         (DONE),
      .rst_n        (rst_n),
      .enable       (enable),
      .disk_addr    (line_disk_addr),
      .line_done    (line_done),
      .disk_rd      (disk_rd),
      .disk_rd_addr (disk_addr),
      .disk_data    (disk_data),
      .disk_valid   (disk_valid),
      .line_ready   (line_ready),
      .line_data    (line_data)
   );

   dma_bus_master u_master (
      .DONE       (DONE),
      .rst_n      (rst_n),
      .enable     (enable),
      .line_ready (line_ready),
      .line_data  (line_data),
      .mem_addr   (mem_addr),
      .br         (br),
      .bg         (bg),
      .ack_in     (ack_in),
      .a_out      (a_out),
      .size_out   (size_out),
      .rw_out     (rw_out),
      .ctrl_oe    (ctrl_oe),
      .d_out      (d_out),
      .d_oe       (d_oe),
      .line_done  (line_done)
   );

endmodule

`default_nettype wire

// ==== logic/dma_slave_regs.sv ====
// DMA register block
`default_nettype none

module dma_slave_regs (
   input  wire                        DONE,
   input  wire                        rst_n,
   input  wire  [dma_pkg::DATA_W-1:0] d_in,
   input  wire  [dma_pkg::ADDR_W-1:0] a_in,
   input  wire                        rw_in,
   input  wire                        dest_in,
   input  wire                        line_done,
   output logic                       ack_out,
   output logic                       enable,
   output logic [dma_pkg::DATA_W-1:0] disk_addr,
   output logic [dma_pkg::DATA_W-1:0] mem_addr,
   output logic [dma_pkg::DATA_W-1:0] remaining,
   output logic                       last_line,
   output logic                       dest_intr
);

   dma_pkg::reg_addr_u addr;
   logic               page_hit;
   logic               wr_hit;

   assign addr.raw = a_in;

   // page compare skips bit 4, it selects the enable register
   assign page_hit = (addr.raw[dma_pkg::ADDR_W-1:5] == dma_pkg::DMA_PAGE[11:1]);
   assign wr_hit   = dest_in && rw_in && page_hit;

   // final line of the transfer is the one in flight
   assign last_line = (remaining == dma_pkg::LINE_BYTES);

   always_ff @(posedge DONE or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ack_out   <= 1'b0;
         enable    <= 1'b0;
         disk_addr <= '0;
         mem_addr  <= '0;
         remaining <= '0;
         dest_intr <= 1'b0;
      end
      else
      begin
         ack_out   <= wr_hit;
         dest_intr <= line_done && last_line;

         // step to the next line once the master has written this one
         if (line_done)
         begin
            disk_addr <= disk_addr + dma_pkg::LINE_BYTES;
            mem_addr  <= mem_addr + dma_pkg::LINE_BYTES;
            remaining <= remaining - dma_pkg::LINE_BYTES;
            if (last_line)
               enable <= 1'b0;
         end

         // processor write wins over the line step
         if (wr_hit)
         begin
            case (addr.f.reg_sel)
               dma_pkg::SEL_DISK_ADDR: disk_addr <= d_in;
               dma_pkg::SEL_MEM_ADDR:  mem_addr  <= d_in;
               dma_pkg::SEL_SIZE:      remaining <= d_in;
               dma_pkg::SEL_ENABLE:    enable    <= d_in[0];
               default:                ;
            endcase
         end
      end
   end

   // master only finishes lines of an armed transfer
   a_done_needs_enable : assert property (
      @(posedge DONE) disable iff (!rst_n)
      line_done |-> enable
   ) else $error("line_done while enable is low");

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset
`default_nettype none

module tb_clock_gen (
   output logic DONE,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   // 8 ns period
   initial
   begin
      DONE = 1'b0;
      forever #4 DONE = ~DONE;
   end

   // reset held for two rising edges
   initial
   begin
      rst_n = 1'b0;
      repeat (2) @(posedge DONE);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_dma_controller.sv ====
// DMA controller testbench
`default_nettype none

module tb_dma_controller;
   timeunit 1ns;
   timeprecision 1ps;

   logic DONE;
   logic rst_n;
   logic [31:0] d_in;
   logic [15:0] a_in;
   logic rw_in;
   logic dest_in;
   logic [31:0] d_out;
   logic [15:0] a_out;
   logic [11:0] size_out;
   logic rw_out;
   logic d_oe;
   logic ctrl_oe;
   logic br;
   logic bg;
   logic ack_out;
   logic ack_in;
   logic dest_intr;
   logic [31:0] disk_addr;
   logic disk_rd;
   logic [31:0] disk_data;
   logic disk_valid;

   // random delay tables filled once after seeding
   int unsigned disk_tab [64];
   int unsigned grant_tab [64];
   int unsigned ack_tab [64];

   int error_count;
   int check_count;
   int intr_count;
   int disk_idx;
   int disk_wait;
   bit disk_busy;
   logic [31:0] disk_req_addr;
   int arb_idx;
   int grant_cnt;
   int ack_cnt;
   int ack_wait;
   int ack_fixed;
   bit ack_sent;
   bit grant_hold;
   bit addr_active;
   int addr_len;
   int beat_run;
   logic [15:0] addr_seen;
   logic [15:0] addr_q [$];
   int addr_len_q [$];
   logic [31:0] data_q [$];

   tb_clock_gen u_clk (.DONE(DONE), .rst_n(rst_n));

   dma_controller u_dut (
      .DONE       (DONE),
      .rst_n      (rst_n),
      .d_in       (d_in),
      .a_in       (a_in),
      .rw_in      (rw_in),
      .dest_in    (dest_in),
      .d_out      (d_out),
      .a_out      (a_out),
      .size_out   (size_out),
      .rw_out     (rw_out),
      .d_oe       (d_oe),
      .ctrl_oe    (ctrl_oe),
      .br         (br),
      .bg         (bg),
      .ack_out    (ack_out),
      .ack_in     (ack_in),
      .dest_intr  (dest_intr),
      .disk_addr  (disk_addr),
      .disk_rd    (disk_rd),
      .disk_data  (disk_data),
      .disk_valid (disk_valid)
   );

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      check_count = check_count + 1;
      if (got !== expected)
      begin
         error_count = error_count + 1;
         $display("mismatch %s: got 0x%h expected 0x%h", name, got, expected);
      end
   endtask

   task automatic report_failure(input string msg);
      error_count = error_count + 1;
      $display("%s", msg);
   endtask

   task automatic abort_on_timeout(input string what);
      error_count = error_count + 1;
      $display("timeout while waiting for %s", what);
      $display("checks: %0d, errors: %0d", check_count, error_count);
      $display("Something failed");
      $finish;
   endtask

   // disk answers each read after 1 to 6 cycles
   always @(posedge DONE)
   begin
      disk_valid <= 1'b0;
      if (disk_busy)
      begin
         if (disk_wait <= 1)
         begin
            disk_data  <= disk_req_addr ^ 32'hA5A5_0000;
            disk_valid <= 1'b1;
            disk_busy  = 1'b0;
         end
         else
            disk_wait = disk_wait - 1;
      end
      else if (rst_n && disk_rd)
      begin
         disk_req_addr = disk_addr;
         disk_wait     = disk_tab[disk_idx % 64];
         disk_idx      = disk_idx + 1;
         disk_busy     = 1'b1;
      end
   end

   // bus arbiter with random grant and ack delays
   always @(posedge DONE)
   begin
      if (!rst_n || !br)
      begin
         if (bg)
            arb_idx = arb_idx + 1;
         bg        <= 1'b0;
         ack_in    <= 1'b0;
         grant_cnt = 0;
         ack_cnt   = 0;
         ack_sent  = 1'b0;
         ack_wait  = (ack_fixed >= 0) ? ack_fixed : ack_tab[arb_idx % 64];
      end
      else if (!bg)
      begin
         if (!grant_hold && grant_cnt >= grant_tab[arb_idx % 64])
            bg <= 1'b1;
         else if (!grant_hold)
            grant_cnt = grant_cnt + 1;
      end
      else if (ctrl_oe && !ack_sent)
      begin
         if (ack_cnt >= ack_wait)
         begin
            ack_in   <= 1'b1;
            ack_sent = 1'b1;
         end
         else
            ack_cnt = ack_cnt + 1;
      end
      else
         ack_in <= 1'b0;
   end

   // memory write checker
   always @(posedge DONE)
   begin
      if (rst_n)
      begin
         if (dest_intr)
            intr_count = intr_count + 1;
         if (ctrl_oe)
         begin
            if (!addr_active)
            begin
               addr_active = 1'b1;
               addr_len    = 0;
               addr_seen   = a_out;
               check_value("size_out", size_out, 32'd16);
               check_value("rw_out", rw_out, 1'b1);
            end
            else
               check_value("a_out", a_out, addr_seen);
            addr_len = addr_len + 1;
         end
         else if (addr_active)
         begin
            addr_active = 1'b0;
            addr_q.push_back(addr_seen);
            addr_len_q.push_back(addr_len);
            if (!d_oe)
               report_failure("data beats did not follow the address phase");
         end
         if (d_oe)
         begin
            data_q.push_back(d_out);
            beat_run = beat_run + 1;
         end
         else if (beat_run != 0)
         begin
            // release cycle right after the last beat
            check_value("beat count", beat_run, 32'd4);
            check_value("br", br, 1'b0);
            check_value("ctrl_oe", ctrl_oe, 1'b0);
            beat_run = 0;
         end
      end
   end

   task automatic reg_write(input logic [15:0] addr, input logic [31:0] data, input bit acked);
      @(posedge DONE);
      a_in    <= addr;
      d_in    <= data;
      rw_in   <= 1'b1;
      dest_in <= 1'b1;
      @(posedge DONE);
      dest_in <= 1'b0;
      rw_in   <= 1'b0;
      check_value("ack_out", ack_out, 1'b0);
      @(posedge DONE);
      check_value("ack_out", ack_out, acked);
      @(posedge DONE);
      check_value("ack_out", ack_out, 1'b0);
   endtask

   task automatic program_transfer(input logic [31:0] disk, input logic [31:0] mem,
                                   input logic [31:0] bytes);
      reg_write(16'h7004, disk, 1'b1);
      reg_write(16'h7008, mem, 1'b1);
      reg_write(16'h700C, bytes, 1'b1);
      reg_write(16'h7010, 32'd1, 1'b1);
   endtask

   task automatic clear_records();
      addr_q.delete();
      addr_len_q.delete();
      data_q.delete();
      intr_count = 0;
   endtask

   task automatic wait_for_intr(input int limit);
      int n;
      n = 0;
      while (intr_count == 0)
      begin
         if (n >= limit)
            abort_on_timeout("dest_intr");
         else
         begin
            @(posedge DONE);
            n = n + 1;
         end
      end
   endtask

   task automatic wait_for_br(input int limit);
      int n;
      n = 0;
      while (br !== 1'b1)
      begin
         if (n >= limit)
            abort_on_timeout("br");
         else
         begin
            @(posedge DONE);
            n = n + 1;
         end
      end
   endtask

   // bus and disk stay silent for the whole window
   task automatic expect_quiet(input int cycles);
      repeat (cycles)
      begin
         @(posedge DONE);
         check_value("br", br, 1'b0);
         check_value("disk_rd", disk_rd, 1'b0);
      end
   endtask

   task automatic expect_stalled(input int cycles);
      repeat (cycles)
      begin
         @(posedge DONE);
         check_value("br", br, 1'b1);
         check_value("ctrl_oe", ctrl_oe, 1'b0);
         check_value("d_oe", d_oe, 1'b0);
      end
   endtask

   // addr_len below zero skips the address phase length
   task automatic check_bursts(input logic [31:0] disk_base, input logic [31:0] mem_base,
                               input int lines, input int addr_len_exp);
      logic [31:0] exp_word;
      logic [31:0] exp_addr;
      check_value("burst count", addr_q.size(), lines);
      check_value("data beats", data_q.size(), lines * 4);
      check_value("dest_intr count", intr_count, 32'd1);
      if (addr_q.size() == lines && data_q.size() == lines * 4)
      begin
         for (int i = 0; i < lines; i++)
         begin
            exp_addr = (mem_base + 16 * i) & 32'h0000_ffff;
            check_value("a_out", addr_q[i], exp_addr);
            if (addr_len_exp >= 0)
               check_value("address phase cycles", addr_len_q[i], addr_len_exp);
            for (int w = 0; w < 4; w++)
            begin
               exp_word = (disk_base + 16 * i + 4 * w) ^ 32'hA5A5_0000;
               check_value("d_out", data_q[i * 4 + w], exp_word);
            end
         end
      end
   endtask

   task automatic test_reset_values();
      check_value("br", br, 1'b0);
      check_value("ack_out", ack_out, 1'b0);
      check_value("d_oe", d_oe, 1'b0);
      check_value("ctrl_oe", ctrl_oe, 1'b0);
      check_value("disk_rd", disk_rd, 1'b0);
      check_value("dest_intr", dest_intr, 1'b0);
   endtask

   task automatic test_register_ack();
      reg_write(16'h7004, 32'h0000_0400, 1'b1);
      // enable word outside the register page
      reg_write(16'h6010, 32'd1, 1'b0);
      expect_quiet(20);
   endtask

   task automatic test_one_line();
      clear_records();
      program_transfer(32'h0000_1200, 32'h0000_3400, 32'd16);
      wait_for_intr(400);
      expect_quiet(20);
      check_bursts(32'h0000_1200, 32'h0000_3400, 1, -1);
   endtask

   task automatic test_four_lines();
      clear_records();
      program_transfer(32'h0001_0000, 32'h0000_8000, 32'd64);
      wait_for_intr(1500);
      expect_quiet(20);
      check_bursts(32'h0001_0000, 32'h0000_8000, 4, -1);
   endtask

   task automatic test_back_pressure();
      clear_records();
      grant_hold = 1'b1;
      ack_fixed  = 6;
      program_transfer(32'h0002_0040, 32'h0000_5000, 32'd32);
      wait_for_br(400);
      expect_stalled(40);
      grant_hold = 1'b0;
      wait_for_intr(1000);
      expect_quiet(20);
      // ack six cycles late stretches the address phase to eight
      check_bursts(32'h0002_0040, 32'h0000_5000, 2, 8);
      ack_fixed = -1;
   endtask

   task automatic test_enable_rewrite();
      clear_records();
      reg_write(16'h7004, 32'h0003_0100, 1'b1);
      reg_write(16'h7008, 32'h0000_6000, 1'b1);
      reg_write(16'h700C, 32'd16, 1'b1);
      reg_write(16'h7010, 32'd0, 1'b1);
      expect_quiet(20);
      reg_write(16'h7010, 32'd1, 1'b1);
      wait_for_intr(400);
      expect_quiet(20);
      check_bursts(32'h0003_0100, 32'h0000_6000, 1, -1);
   endtask

   task automatic fill_random_delays();
      for (int i = 0; i < 64; i++)
      begin
         disk_tab[i]  = $urandom_range(6, 1);
         grant_tab[i] = $urandom_range(5, 0);
         ack_tab[i]   = $urandom_range(3, 0);
      end
   endtask

   initial
   begin
      int n;
      d_in        = '0;
      a_in        = '0;
      rw_in       = 1'b0;
      dest_in     = 1'b0;
      bg          = 1'b0;
      ack_in      = 1'b0;
      disk_data   = '0;
      disk_valid  = 1'b0;
      error_count = 0;
      check_count = 0;
      intr_count  = 0;
      disk_idx    = 0;
      disk_busy   = 1'b0;
      arb_idx     = 0;
      ack_fixed   = -1;
      grant_hold  = 1'b0;
      addr_active = 1'b0;
      beat_run    = 0;
      void'($urandom(3339));
      fill_random_delays();

      n = 0;
      while (rst_n !== 1'b1)
      begin
         if (n >= 20)
            abort_on_timeout("reset release");
         else
         begin
            @(posedge DONE);
            n = n + 1;
         end
      end
      @(posedge DONE);

      test_reset_values();
      test_register_ack();
      test_one_line();
      test_four_lines();
      test_back_pressure();
      test_enable_rewrite();

      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire
